//--- Bender.yml
package:
  name: tart_axi_wb

sources:
  # Design, in dependency order
  - src/tart_bridge_pkg.sv
  - src/wb_bus_if.sv
  - src/bridge_req_if.sv
  - src/axi_lite_slave.sv
  - src/wb_transfer_bridge.sv
  - src/wb_cycle.sv
  - src/tart_axi_wb_top.sv

  # Testbench
  - target: test
    files:
      - dv/wb_reg_target.sv
      - dv/tb_tart_axi_wb.sv

//--- dv/tb_tart_axi_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tart_axi_wb
    import tart_bridge_pkg::*;
();

    localparam int WB_ADDR_WIDTH  = 7;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int SEED           = 32'h9cb6_1a33;

    logic                        S_AXI_ACLK;
    logic                        S_AXI_ARESETN;
    logic [WB_ADDR_WIDTH+1:0]    awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [AXI_DATA_WIDTH-1:0]   wdata;
    logic [AXI_DATA_WIDTH/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    axi_resp_e                   bresp;
    logic                        bvalid;
    logic                        bready;
    logic [WB_ADDR_WIDTH+1:0]    araddr;
    logic                        arvalid;
    logic                        arready;
    logic [AXI_DATA_WIDTH-1:0]   rdata;
    axi_resp_e                   rresp;
    logic                        rvalid;
    logic                        rready;
    // Wishbone between the bridge and the register target
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [WB_ADDR_WIDTH-1:0]    wb_adr;
    wb_data_t                    wb_dat_w;
    wb_data_t                    wb_dat_r;
    logic                        wb_ack;
    logic                        wb_wat;
    logic                        wb_rty;
    logic                        wb_err;

    // Expected register contents
    wb_data_t model [2**WB_ADDR_WIDTH];
    int       cycles = 0;

    tart_axi_wb_top #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) dut0 (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .awaddr_i (awaddr),  .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i  (wdata),   .wstrb_i   (wstrb),   .wvalid_i  (wvalid),  .wready_o (wready),
        .bresp_o  (bresp),   .bvalid_o  (bvalid),  .bready_i  (bready),
        .araddr_i (araddr),  .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o  (rdata),   .rresp_o   (rresp),   .rvalid_o  (rvalid),  .rready_i (rready),
        .wb_cyc_o (wb_cyc),  .wb_stb_o  (wb_stb),  .wb_we_o   (wb_we),
        .wb_adr_o (wb_adr),  .wb_dat_o  (wb_dat_w), .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack),  .wb_wat_i  (wb_wat),  .wb_rty_i  (wb_rty),  .wb_err_i (wb_err)
    );

    wb_reg_target #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) target0 (
        .s_axi_aclk_i (S_AXI_ACLK), .s_axi_aresetn_i (S_AXI_ARESETN),
        .cyc_i (wb_cyc), .stb_i (wb_stb), .we_i (wb_we), .adr_i (wb_adr),
        .dat_i (wb_dat_w), .dat_o (wb_dat_r), .ack_o (wb_ack), .wat_o (wb_wat),
        .rty_o (wb_rty), .err_o (wb_err)
    );

    always #5 S_AXI_ACLK = ~S_AXI_ACLK;

    // Watchdog on the total run length
    always @(posedge S_AXI_ACLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
    end

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
        if (got !== exp)
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                                        $time, name, got, exp));
    endtask

    task automatic check_data(input string name, input logic [AXI_DATA_WIDTH-1:0] got,
                              input logic [AXI_DATA_WIDTH-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                                        $time, name, got, exp));
    endtask

    // ----------------------------------------
    // AXI4-Lite host transactions
    // ----------------------------------------
    task automatic axi_write(input logic [WB_ADDR_WIDTH-1:0] reg_adr,
                             input logic [AXI_DATA_WIDTH-1:0] data,
                             input logic [3:0] strb, input axi_resp_e exp_resp);
        int unsigned hold;
        hold    = $urandom_range(0, 5);
        awaddr  <= {reg_adr, 2'b00};
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!awready);
        if (!wready)
            stop_with_failure("WREADY did not pulse together with AWREADY");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge S_AXI_ACLK); while (!bvalid);
        // Host lets the response wait
        repeat (hold)
        begin
            @(posedge S_AXI_ACLK);
            if (!bvalid)
                stop_with_failure("BVALID dropped before BREADY was raised");
        end
        check_resp("bresp", bresp, exp_resp);
        bready <= 1'b1;
        @(posedge S_AXI_ACLK);
        bready <= 1'b0;
        // Only lane 0 reaches the register
        if (exp_resp == RESP_OKAY && strb[0])
            model[reg_adr] = data[WB_DATA_WIDTH-1:0];
    endtask

    task automatic axi_read(input logic [WB_ADDR_WIDTH-1:0] reg_adr,
                            input logic [AXI_DATA_WIDTH-1:0] exp_data,
                            input axi_resp_e exp_resp);
        int unsigned hold;
        hold    = $urandom_range(0, 5);
        araddr  <= {reg_adr, 2'b00};
        arvalid <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!arready);
        arvalid <= 1'b0;
        do @(posedge S_AXI_ACLK); while (!rvalid);
        repeat (hold)
        begin
            @(posedge S_AXI_ACLK);
            if (!rvalid)
                stop_with_failure("RVALID dropped before RREADY was raised");
        end
        check_resp("rresp", rresp, exp_resp);
        check_data("rdata", rdata, exp_data);
        rready <= 1'b1;
        @(posedge S_AXI_ACLK);
        rready <= 1'b0;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic write_read_back();
        logic [WB_ADDR_WIDTH-1:0] adrs [20];
        // Ordinary registers stay below the special ones
        foreach (adrs[i])
        begin
            adrs[i] = WB_ADDR_WIDTH'($urandom_range(0, 'h7B));
            axi_write(adrs[i], $urandom, 4'hF, RESP_OKAY);
        end
        foreach (adrs[i])
            axi_read(adrs[i], AXI_DATA_WIDTH'(model[adrs[i]]), RESP_OKAY);
    endtask

    task automatic stall_wait_sweep();
        logic [WB_ADDR_WIDTH-1:0] a;
        // Every stall and wait-state combination in bits 2:0
        for (int low = 0; low < 8; low++)
        begin
            a = {4'($urandom_range(0, 14)), 3'(low)};
            axi_write(a, $urandom, 4'hF, RESP_OKAY);
            axi_read(a, AXI_DATA_WIDTH'(model[a]), RESP_OKAY);
        end
    endtask

    task automatic strobe_skip();
        logic [WB_ADDR_WIDTH-1:0] a;
        a = WB_ADDR_WIDTH'($urandom_range(0, 'h7B));
        axi_write(a, 32'h0000_005A, 4'hF, RESP_OKAY);
        // Register keeps 5A with lane 0 off
        axi_write(a, 32'hFFFF_FFA5, 4'hE, RESP_OKAY);
        axi_read(a, 32'h0000_005A, RESP_OKAY);
    endtask

    task automatic error_and_timeout();
        axi_write(7'h7F, $urandom, 4'hF, RESP_SLVERR);
        axi_read(7'h7F, '0, RESP_SLVERR);
        // Silent target makes the framer give up
        axi_write(7'h7E, $urandom, 4'hF, RESP_SLVERR);
        axi_read(7'h7E, '0, RESP_SLVERR);
    endtask

    task automatic retry_paths();
        axi_write(7'h7D, 32'h0000_00C3, 4'hF, RESP_OKAY);
        axi_read(7'h7D, 32'h0000_00C3, RESP_OKAY);
        axi_write(7'h7C, $urandom, 4'hF, RESP_SLVERR);
        axi_read(7'h7C, '0, RESP_SLVERR);
    endtask

    task automatic write_priority();
        logic [WB_ADDR_WIDTH-1:0]  a;
        logic [AXI_DATA_WIDTH-1:0] d;
        a = WB_ADDR_WIDTH'($urandom_range(0, 'h7B));
        d = $urandom;
        // All three valids rise on the same edge
        fork
            axi_write(a, d, 4'hF, RESP_OKAY);
            axi_read(a, AXI_DATA_WIDTH'(d[WB_DATA_WIDTH-1:0]), RESP_OKAY);
        join
    endtask

    initial
    begin
        void'($urandom(SEED));
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        foreach (model[i])
            model[i] = '0;
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge S_AXI_ACLK);

        write_read_back();
        stall_wait_sweep();
        strobe_skip();
        error_and_timeout();
        retry_paths();
        write_priority();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/wb_reg_target.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral byte register bank on a Wishbone B4 pipelined bus
module wb_reg_target import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7
) (
    input  logic                     s_axi_aclk_i,
    input  logic                     s_axi_aresetn_i,
    input  logic                     cyc_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [WB_ADDR_WIDTH-1:0] adr_i,
    input  wb_data_t                 dat_i,
    output wb_data_t                 dat_o,
    output logic                     ack_o,
    output logic                     wat_o,
    output logic                     rty_o,
    output logic                     err_o
);

    // Special registers at the top of the map
    localparam logic [WB_ADDR_WIDTH-1:0] ADR_ERR   = 7'h7F;
    localparam logic [WB_ADDR_WIDTH-1:0] ADR_MUTE  = 7'h7E;
    localparam logic [WB_ADDR_WIDTH-1:0] ADR_RTY2  = 7'h7D;
    localparam logic [WB_ADDR_WIDTH-1:0] ADR_RTYAL = 7'h7C;

    wb_data_t                 regs [2**WB_ADDR_WIDTH];
    logic                     stalled_q;
    logic                     pending_q;
    logic [1:0]               wait_q;
    logic [WB_ADDR_WIDTH-1:0] adr_q;
    logic                     we_q;
    wb_data_t                 dat_q;
    logic [1:0]               rty_seen_q;
    logic                     accept;
    logic                     term;
    logic [WB_ADDR_WIDTH-1:0] t_adr;
    logic                     t_we;
    wb_data_t                 t_dat;
    logic                     do_ack;
    logic                     do_err;
    logic                     do_rty;

    // Address bit 2 stalls the first cycle of each request
    assign wat_o  = cyc_i && stb_i && adr_i[2] && !stalled_q;
    assign accept = cyc_i && stb_i && !wat_o;
    // No wait states means a reply right after acceptance
    assign term   = (accept && adr_i[1:0] == 2'd0) || (pending_q && wait_q == 2'd0);
    assign t_adr  = pending_q ? adr_q : adr_i;
    assign t_we   = pending_q ? we_q : we_i;
    assign t_dat  = pending_q ? dat_q : dat_i;

    // Reply decode for the request that ends now
    assign do_err = term && t_adr == ADR_ERR;
    assign do_rty = term && (t_adr == ADR_RTYAL || (t_adr == ADR_RTY2 && rty_seen_q < 2'd2));
    // The mute register never answers
    assign do_ack = term && !do_err && !do_rty && t_adr != ADR_MUTE;

    always @(posedge s_axi_aclk_i)
    begin
        if (!s_axi_aresetn_i)
        begin
            for (int i = 0; i < 2**WB_ADDR_WIDTH; i++)
                regs[i] <= '0;
            stalled_q  <= 1'b0;
            pending_q  <= 1'b0;
            wait_q     <= '0;
            rty_seen_q <= '0;
            ack_o      <= 1'b0;
            err_o      <= 1'b0;
            rty_o      <= 1'b0;
            dat_o      <= '0;
        end
        else
        begin
            stalled_q <= wat_o;
            ack_o     <= do_ack;
            err_o     <= do_err;
            rty_o     <= do_rty;

            // Wait-state countdown for an accepted request
            if (term)
                pending_q <= 1'b0;
            else if (accept)
            begin
                pending_q <= 1'b1;
                wait_q    <= adr_i[1:0] - 2'd1;
                adr_q     <= adr_i;
                we_q      <= we_i;
                dat_q     <= dat_i;
            end
            else if (pending_q)
                wait_q <= wait_q - 2'd1;

            if (do_ack && t_we)
                regs[t_adr] <= t_dat;
            if (do_ack)
                dat_o <= regs[t_adr];

            // Two retries, then an ack that starts the count over
            if (term && t_adr == ADR_RTY2)
                rty_seen_q <= do_rty ? rty_seen_q + 2'd1 : 2'd0;
        end
    end

endmodule

`default_nettype wire

//--- src/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7
) (
    input  logic                          s_axi_aclk_i,
    input  logic                          s_axi_aresetn_i,
    // Write address and data
    input  logic [WB_ADDR_WIDTH+1:0]      awaddr_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [AXI_DATA_WIDTH-1:0]     wdata_i,
    input  logic [AXI_DATA_WIDTH/8-1:0]   wstrb_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    // Write response
    output axi_resp_e                     bresp_o,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    // Read address
    input  logic [WB_ADDR_WIDTH+1:0]      araddr_i,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    // Read data and response
    output logic [AXI_DATA_WIDTH-1:0]     rdata_o,
    output axi_resp_e                     rresp_o,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    // Towards the transfer bridge
    bridge_req_if.front                   req
);

    // ----------------------------------------
    // Admission
    // ----------------------------------------

    // High from the ready pulse until the host takes the response
    logic busy_q;
    logic idle;
    logic wr_go;
    logic rd_go;

    assign idle  = !busy_q;
    // Write needs address and data together
    assign wr_go = idle && awvalid_i && wvalid_i;
    // Write wins a same-cycle collision
    assign rd_go = idle && arvalid_i && !(awvalid_i && wvalid_i);

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge s_axi_aclk_i)
    begin
        if (!s_axi_aresetn_i)
        begin
            busy_q        <= 1'b0;
            awready_o     <= 1'b0;
            wready_o      <= 1'b0;
            arready_o     <= 1'b0;
            req.req_valid <= 1'b0;
            bvalid_o      <= 1'b0;
            rvalid_o      <= 1'b0;
        end
        else
        begin
            // Readies are single-cycle pulses, busy_q blocks a second one
            awready_o <= wr_go;
            wready_o  <= wr_go;
            arready_o <= rd_go;

            if (wr_go || rd_go)
                busy_q <= 1'b1;
            else if ((bvalid_o && bready_i) || (rvalid_o && rready_i))
                busy_q <= 1'b0;

            // Request goes out the cycle after the address handshake
            if (awready_o || arready_o)
                req.req_valid <= 1'b1;
            else if (req.rsp_valid)
                req.req_valid <= 1'b0;

            // Response channels held until the host is ready
            if (req.rsp_valid && req.req_write)
                bvalid_o <= 1'b1;
            else if (bready_i)
                bvalid_o <= 1'b0;

            if (req.rsp_valid && !req.req_write)
                rvalid_o <= 1'b1;
            else if (rready_i)
                rvalid_o <= 1'b0;
        end
    end

    // ----------------------------------------
    // Request and response payload
    // ----------------------------------------
    always_ff @(posedge s_axi_aclk_i)
    begin
        // Host keeps address and data stable while ready is high
        if (awready_o)
        begin
            req.req_write <= 1'b1;
            req.req_addr  <= awaddr_i[WB_ADDR_WIDTH+1:2];
            req.req_wdata <= wdata_i[WB_DATA_WIDTH-1:0];
            // Only lane 0 carries a register byte
            req.req_skip  <= !wstrb_i[0];
        end
        else if (arready_o)
        begin
            req.req_write <= 1'b0;
            req.req_addr  <= araddr_i[WB_ADDR_WIDTH+1:2];
            req.req_skip  <= 1'b0;
        end

        if (req.rsp_valid && req.req_write)
            bresp_o <= req.rsp_resp;

        if (req.rsp_valid && !req.req_write)
        begin
            rresp_o <= req.rsp_resp;
            // Byte register read back zero-extended
            rdata_o <= {{(AXI_DATA_WIDTH-WB_DATA_WIDTH){1'b0}}, req.rsp_rdata};
        end
    end

    // Responses hold steady until accepted
    bvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    rvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

`default_nettype wire

//--- src/bridge_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Single-request channel from the AXI front end to the transfer bridge
interface bridge_req_if import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7
) ();

    // Request, held by the front end until rsp_valid
    logic                     req_valid;
    logic                     req_write;
    logic [WB_ADDR_WIDTH-1:0] req_addr;
    wb_data_t                 req_wdata;
    // Write with the low byte strobe clear, answered without a bus cycle
    logic                     req_skip;

    // Response, rsp_valid lasts exactly one cycle
    logic                     rsp_valid;
    wb_data_t                 rsp_rdata;
    axi_resp_e                rsp_resp;

    modport front (output req_valid, req_write, req_addr, req_wdata, req_skip,
                   input  rsp_valid, rsp_rdata, rsp_resp);

    modport back  (input  req_valid, req_write, req_addr, req_wdata, req_skip,
                   output rsp_valid, rsp_rdata, rsp_resp);

endinterface

`default_nettype wire

//--- src/tart_axi_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tart_axi_wb_top import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7,
    parameter int ACK_TIMEOUT   = 15,
    parameter int RETRY_LIMIT   = 3
) (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    // AXI4-Lite slave port
    input  logic [WB_ADDR_WIDTH+1:0]    awaddr_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [AXI_DATA_WIDTH-1:0]   wdata_i,
    input  logic [AXI_DATA_WIDTH/8-1:0] wstrb_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output axi_resp_e                   bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic [WB_ADDR_WIDTH+1:0]    araddr_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output logic [AXI_DATA_WIDTH-1:0]   rdata_o,
    output axi_resp_e                   rresp_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    // Wishbone B4 master port
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [WB_ADDR_WIDTH-1:0]    wb_adr_o,
    output wb_data_t                    wb_dat_o,
    input  wb_data_t                    wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_wat_i,
    input  logic                        wb_rty_i,
    input  logic                        wb_err_i
);

    logic       start;
    logic       busy;
    logic       done;
    wb_result_e result;

    wb_bus_if     #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) wb_bus ();
    bridge_req_if #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) req_bus ();

    // ----------------------------------------
    // Wishbone pins
    // ----------------------------------------
    assign wb_cyc_o      = wb_bus.cyc;
    assign wb_stb_o      = wb_bus.stb;
    assign wb_we_o       = wb_bus.we;
    assign wb_adr_o      = wb_bus.adr;
    assign wb_dat_o      = wb_bus.dat_w;
    assign wb_bus.dat_r  = wb_dat_i;
    assign wb_bus.ack    = wb_ack_i;
    assign wb_bus.wat    = wb_wat_i;
    assign wb_bus.rty    = wb_rty_i;
    assign wb_bus.err    = wb_err_i;

    axi_lite_slave #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) u_axi (
        .s_axi_aclk_i    (S_AXI_ACLK),
        .s_axi_aresetn_i (S_AXI_ARESETN),
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .req             (req_bus.front)
    );

    wb_transfer_bridge #(.WB_ADDR_WIDTH(WB_ADDR_WIDTH)) u_bridge (
        .s_axi_aclk_i    (S_AXI_ACLK),
        .s_axi_aresetn_i (S_AXI_ARESETN),
        .start_o         (start),
        .busy_i          (busy),
        .done_i          (done),
        .result_i        (result),
        .req             (req_bus.back),
        .wb              (wb_bus.master)
    );

    wb_cycle #(.ACK_TIMEOUT(ACK_TIMEOUT), .RETRY_LIMIT(RETRY_LIMIT)) u_cycle (
        .s_axi_aclk_i    (S_AXI_ACLK),
        .s_axi_aresetn_i (S_AXI_ARESETN),
        .start_i         (start),
        .busy_o          (busy),
        .done_o          (done),
        .result_o        (result),
        .wb              (wb_bus.master)
    );

endmodule

`default_nettype wire

//--- src/tart_bridge_pkg.sv
`default_nettype none

// ----------------------------------------
// Shared widths and codes for the AXI4-Lite to Wishbone bridge
// ----------------------------------------
package tart_bridge_pkg;

    // Each Wishbone register is one byte wide
    localparam int WB_DATA_WIDTH = 8;

    // Host side sees full 32-bit words
    localparam int AXI_DATA_WIDTH = 32;

    // AXI response codes, only the two the bridge ever returns
    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // How a framed Wishbone cycle came to an end
    typedef enum logic [1:0]
    {
        WB_ACK             = 2'd0,
        WB_ERR             = 2'd1,
        WB_TIMEOUT         = 2'd2,
        WB_RETRY_EXHAUSTED = 2'd3
    } wb_result_e;

    // Register payload
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

`default_nettype wire

//--- src/wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone B4 pipelined bus, byte data, no selects
interface wb_bus_if import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7
) ();

    // Cycle framing
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    wb_data_t                 dat_w;

    // Target replies
    wb_data_t                 dat_r;
    logic                     ack;
    logic                     wat;
    logic                     rty;
    logic                     err;

    // Framer and transfer bridge share the master side
    modport master (output cyc, stb, we, adr, dat_w,
                    input  dat_r, ack, wat, rty, err);

    // Register bank side
    modport target (input  cyc, stb, we, adr, dat_w,
                    output dat_r, ack, wat, rty, err);

endinterface

`default_nettype wire

//--- src/wb_cycle.sv
`timescale 1ns/1ps
`default_nettype none

module wb_cycle import tart_bridge_pkg::*; #(
    parameter int ACK_TIMEOUT = 15,
    parameter int RETRY_LIMIT = 3
) (
    input  logic       s_axi_aclk_i,
    input  logic       s_axi_aresetn_i,
    input  logic       start_i,
    output logic       busy_o,
    output logic       done_o,
    output wb_result_e result_o,
    wb_bus_if.master   wb
);

    localparam int TMO_W = $clog2(ACK_TIMEOUT + 1);
    localparam int RTY_W = $clog2(RETRY_LIMIT + 1);
    localparam logic [TMO_W-1:0] TMO_LAST  = TMO_W'(ACK_TIMEOUT - 1);
    localparam logic [RTY_W-1:0] RTY_LIMIT = RTY_W'(RETRY_LIMIT);

    // Idle, strobe out and waiting on a stall, accepted and waiting on a termination
    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

    state_e           state_q;
    logic [TMO_W-1:0] tmo_q;
    logic [RTY_W-1:0] retry_q;
    logic             finish;
    wb_result_e       next_result;

    assign busy_o = (state_q != ST_IDLE);

    // Termination decode, only valid once the request was accepted
    always_comb
    begin
        finish      = 1'b0;
        next_result = WB_ACK;
        if (state_q == ST_WAIT)
        begin
            if (wb.ack)
                finish = 1'b1;
            else if (wb.err)
            begin
                finish      = 1'b1;
                next_result = WB_ERR;
            end
            else if (wb.rty && retry_q == RTY_LIMIT)
            begin
                finish      = 1'b1;
                next_result = WB_RETRY_EXHAUSTED;
            end
            else if (!wb.rty && tmo_q == TMO_LAST)
            begin
                finish      = 1'b1;
                next_result = WB_TIMEOUT;
            end
        end
    end

    // ----------------------------------------
    // Cycle FSM
    // ----------------------------------------
    always_ff @(posedge s_axi_aclk_i)
    begin
        if (!s_axi_aresetn_i)
        begin
            state_q <= ST_IDLE;
            wb.cyc  <= 1'b0;
            wb.stb  <= 1'b0;
            done_o  <= 1'b0;
            tmo_q   <= '0;
            retry_q <= '0;
        end
        else
        begin
            done_o <= finish;
            case (state_q)
                ST_IDLE:
                    if (start_i)
                    begin
                        state_q <= ST_REQ;
                        wb.cyc  <= 1'b1;
                        wb.stb  <= 1'b1;
                        retry_q <= '0;
                    end
                // Strobe stays up through stall cycles
                ST_REQ:
                    if (!wb.wat)
                    begin
                        state_q <= ST_WAIT;
                        wb.stb  <= 1'b0;
                        tmo_q   <= '0;
                    end
                ST_WAIT:
                    if (finish)
                    begin
                        state_q <= ST_IDLE;
                        wb.cyc  <= 1'b0;
                    end
                    else if (wb.rty)
                    begin
                        // Same address and data go out again, cyc kept
                        state_q <= ST_REQ;
                        wb.stb  <= 1'b1;
                        retry_q <= retry_q + 1'b1;
                    end
                    else
                        tmo_q <= tmo_q + 1'b1;
                default:
                    state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk_i)
    begin
        if (finish)
            result_o <= next_result;
    end

    stb_in_cyc: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
        wb.stb |-> wb.cyc);

    // Target may only terminate inside a cycle
    term_in_cyc: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
        !wb.cyc |-> !(wb.ack || wb.err || wb.rty));

endmodule

`default_nettype wire

//--- src/wb_transfer_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_transfer_bridge import tart_bridge_pkg::*; #(
    parameter int WB_ADDR_WIDTH = 7
) (
    input  logic        s_axi_aclk_i,
    input  logic        s_axi_aresetn_i,
    // Cycle framer handshake
    output logic        start_o,
    input  logic        busy_i,
    input  logic        done_i,
    input  wb_result_e  result_i,
    bridge_req_if.back  req,
    wb_bus_if.master    wb
);

    // Set while a request is being served
    logic     active_q;
    logic     launch;
    // Read byte taken on ack
    wb_data_t rd_q;

    // Fresh request seen on the first cycle of req_valid
    assign launch = req.req_valid && !active_q;

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge s_axi_aclk_i)
    begin
        if (!s_axi_aresetn_i)
        begin
            active_q      <= 1'b0;
            start_o       <= 1'b0;
            req.rsp_valid <= 1'b0;
        end
        else
        begin
            start_o       <= launch && !req.req_skip;
            // Skipped writes answer straight away
            req.rsp_valid <= (launch && req.req_skip) || done_i;

            if (launch)
                active_q <= 1'b1;
            else if (req.rsp_valid)
                active_q <= 1'b0;
        end
    end

    // ----------------------------------------
    // Bus fields and result mapping
    // ----------------------------------------
    always_ff @(posedge s_axi_aclk_i)
    begin
        // Held for every retry of the cycle
        if (launch)
        begin
            wb.adr   <= req.req_addr;
            wb.we    <= req.req_write;
            wb.dat_w <= req.req_wdata;
        end

        if (wb.cyc && wb.ack)
            rd_q <= wb.dat_r;

        if (launch && req.req_skip)
        begin
            req.rsp_rdata <= '0;
            req.rsp_resp  <= RESP_OKAY;
        end
        else if (done_i)
        begin
            // Anything but a clean ack is a slave error with no data
            req.rsp_resp  <= (result_i == WB_ACK) ? RESP_OKAY : RESP_SLVERR;
            req.rsp_rdata <= (result_i == WB_ACK) ? rd_q : '0;
        end
    end

    // Framer must be free whenever a cycle is launched
    start_when_free: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
        start_o |-> !busy_i);

endmodule

`default_nettype wire

//--- vlog.f
src/tart_bridge_pkg.sv
src/wb_bus_if.sv
src/bridge_req_if.sv
src/axi_lite_slave.sv
src/wb_transfer_bridge.sv
src/wb_cycle.sv
src/tart_axi_wb_top.sv
dv/wb_reg_target.sv
dv/tb_tart_axi_wb.sv
